//--- sources.f
+incdir+.
mlpPkg.sv
neuronNode.sv
denseLayer.sv
handshakeControl.sv
mlpTop.sv
mlpTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP ?= mlpTb
FILELIST ?= sources.f
BUILD ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= sim passed

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   list these targets"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

test: build
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "RESULT: PASS"; \
	else \
		echo "RESULT: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- mlpTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlp_settings.svh"

module mlpTb
	import mlpPkg::*;
();

	localparam int tableLength = 14;
	localparam int randomStart = 6;
	localparam int clockPeriod = 40;
	localparam int cyclesPerTest = 40;
	localparam int driveDelay = 2;
	localparam int seed = 52628;
	localparam int maxAckDelay = 5;
	localparam int saturateLimit = 1 << (`MLP_FRAC_SHIFT + `MLP_ACT_WIDTH - 1);

	logic clk;
	logic reset;
	logic inReq;
	logic inAck;
	featureVector features;
	logic outReq;
	logic outAck;
	scoreVector scores;

	string names [tableLength];
	featureVector vectors [tableLength];
	scoreVector expected [tableLength];
	logic [2:0] wantCases [tableLength]; // negative, saturate, round clamp.

	logic prevInReq;
	logic prevInAck;
	logic prevOutReq;
	logic prevOutAck;
	scoreVector prevScores;

	mlpTop u_mlpTop (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inAck(inAck),
		.features(features),
		.outReq(outReq),
		.outAck(outAck),
		.scores(scores)
	);

	always #(clockPeriod / 2) clk = ~clk;

	task automatic checkScores(input string name, input scoreVector want, input scoreVector got);
		if (want !== got)
		begin
			$display("ERR %s: expected %h, actual %h", name, want, got);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic checkHandshake(input string label, input logic want, input logic got);
		if (want !== got)
		begin
			$display("ERR %s: expected %b, actual %b", label, want, got);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// one neuron after its sum is known.
	task automatic neuronModel(input int acc, output activation value, output logic [2:0] hit);
		int rounded;
		hit = 3'b000;
		if (acc < 0)
		begin
			value = '0;
			hit = 3'b001;
		end
		else if (acc >= saturateLimit)
		begin
			value = activation'(`MLP_ACT_MAX);
			hit = 3'b010;
		end
		else
		begin
			rounded = (acc >>> `MLP_FRAC_SHIFT) + ((acc >>> (`MLP_FRAC_SHIFT - 1)) & 1);
			if (rounded > `MLP_ACT_MAX)
			begin
				value = activation'(`MLP_ACT_MAX); // 127.5 case.
				hit = 3'b100;
			end
			else
				value = activation'(rounded);
		end
	endtask

	task automatic networkModel(input featureVector x, output scoreVector y,
		output logic [2:0] hits);
		featureVector hidden;
		activation value;
		logic [2:0] hit;
		int acc;
		hits = 3'b000;
		hidden = '0;
		y = '0;
		for (int n = 0; n < `MLP_HIDDEN; n++)
		begin
			acc = int'(hiddenBiases[n]);
			for (int i = 0; i < `MLP_FEATURES; i++)
				acc += int'(x.act[i]) * int'(hiddenWeights[n][i]);
			neuronModel(acc, value, hit);
			hidden.act[n] = value;
			hits |= hit;
		end
		for (int n = 0; n < `MLP_OUTPUTS; n++)
		begin
			acc = int'(outputBiases[n]);
			for (int i = 0; i < `MLP_HIDDEN; i++)
				acc += int'(hidden.act[i]) * int'(outputWeights[n][i]);
			neuronModel(acc, value, hit);
			y.act[n] = value;
			hits |= hit;
		end
	endtask

	task automatic buildTable();
		logic [2:0] hits;
		names[0] = "zeros";
		vectors[0] = '0;
		names[1] = "allNegative";
		names[2] = "saturate";
		vectors[2] = '0;
		names[3] = "roundClamp";
		vectors[3] = '0;
		names[4] = "allPositive";
		names[5] = "alternating";
		for (int j = 0; j < `MLP_FEATURES; j++)
		begin
			vectors[1].act[j] = -8'sd128;
			vectors[4].act[j] = 8'sd127;
			vectors[5].act[j] = (j % 2 == 0) ? 8'sd127 : -8'sd128;
		end
		// hidden node 6 sums far past the output field.
		vectors[2].act[0] = 8'sd127;
		vectors[2].act[1] = 8'sd127;
		vectors[2].act[3] = 8'sd127;
		vectors[2].act[5] = 8'sd127;
		vectors[2].act[8] = 8'sd127;
		vectors[2].act[9] = 8'sd127;
		// hidden node 5 lands on 8175, field 127 with bit 5 set.
		vectors[3].act[2] = 8'sd127;
		vectors[3].act[4] = 8'sd70;
		vectors[3].act[9] = 8'sd127;
		for (int i = randomStart; i < tableLength; i++)
		begin
			names[i] = $sformatf("random%0d", i);
			for (int j = 0; j < `MLP_FEATURES; j++)
				vectors[i].act[j] = activation'($urandom_range(255, 0));
		end
		for (int i = 0; i < tableLength; i++)
			wantCases[i] = 3'b000;
		wantCases[0] = 3'b001;
		wantCases[2] = 3'b010;
		wantCases[3] = 3'b100;
		for (int i = 0; i < tableLength; i++)
		begin
			networkModel(vectors[i], expected[i], hits);
			if ((hits & wantCases[i]) != wantCases[i])
			begin
				$display("directed vector %s misses the neuron case it was built for", names[i]);
				$display("sim failed");
				$fatal(1);
			end
		end
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#(driveDelay);
	endtask

	// protocol rules, sampled mid-cycle.
	always @(negedge clk)
	begin
		if (reset)
		begin
			prevInReq <= 1'b0;
			prevInAck <= 1'b0;
			prevOutReq <= 1'b0;
			prevOutAck <= 1'b0;
			prevScores <= '0;
		end
		else
		begin
			if (inAck && !prevInAck)
			begin
				checkHandshake("inReq high before inAck rises", 1'b1, prevInReq);
				checkHandshake("outReq low before inAck rises", 1'b0, prevOutReq);
				checkHandshake("outAck low before inAck rises", 1'b0, prevOutAck);
			end
			if (!inAck && prevInAck)
				checkHandshake("inReq low before inAck falls", 1'b0, prevInReq);
			if (outReq && !prevOutReq)
				checkHandshake("outAck low before outReq rises", 1'b0, prevOutAck);
			if (!outReq && prevOutReq)
				checkHandshake("outAck high before outReq falls", 1'b1, prevOutAck);
			if (outReq && prevOutReq)
				checkScores("scores held while outReq high", prevScores, scores);
			prevInReq <= inReq;
			prevInAck <= inAck;
			prevOutReq <= outReq;
			prevOutAck <= outAck;
			prevScores <= scores;
		end
	end

	initial
	begin
		#(tableLength * cyclesPerTest * clockPeriod);
		$display("timeout: the DUT stopped answering its handshakes");
		$display("sim failed");
		$fatal(1);
	end

	initial
	begin
		int unsigned seedValue;
		int ackDelay;
		logic pending;
		logic overlap;
		clk = 1'b0;
		reset = 1'b1;
		inReq = 1'b0;
		outAck = 1'b0;
		features = '0;
		seedValue = $urandom(seed);
		buildTable();
		repeat (5) @(posedge clk);
		#(driveDelay);
		reset = 1'b0;
		checkHandshake("inAck after reset", 1'b0, inAck);
		checkHandshake("outReq after reset", 1'b0, outReq);
		pending = 1'b0;
		for (int i = 0; i < tableLength; i++)
		begin
			if (!pending)
			begin
				features = vectors[i];
				inReq = 1'b1;
			end
			pending = 1'b0;
			do nextCycle(); while (!inAck);
			inReq = 1'b0;
			do nextCycle(); while (inAck);
			do nextCycle(); while (!outReq);
			checkScores(names[i], expected[i], scores);
			// odd entries push the next request against a held result.
			overlap = (i % 2 == 1) && (i + 1 < tableLength);
			if (overlap)
			begin
				features = vectors[i + 1];
				inReq = 1'b1;
				pending = 1'b1;
			end
			ackDelay = int'($urandom_range(maxAckDelay, 0));
			repeat (ackDelay)
			begin
				nextCycle();
				if (overlap)
					checkHandshake({names[i + 1], " held off"}, 1'b0, inAck);
			end
			outAck = 1'b1;
			do nextCycle(); while (outReq);
			outAck = 1'b0;
		end
		repeat (2) nextCycle();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- mlpTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlp_settings.svh"

module mlpTop
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inReq,
	output logic inAck,
	input featureVector features,
	output logic outReq,
	input logic outAck,
	output scoreVector scores
);

	featureVector captured;
	featureVector hiddenOut;
	scoreVector layerScores;

	handshakeControl u_control (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inAck(inAck),
		.features(features),
		.captured(captured),
		.layerScores(layerScores),
		.outReq(outReq),
		.outAck(outAck),
		.scores(scores)
	);

	denseLayer #(
		.width(`MLP_HIDDEN),
		.layerIndex(hiddenIndex)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.layerIn(captured),
		.layerOut(hiddenOut.act)
	);

	// hidden outputs reuse the feature vector type.
	denseLayer #(
		.width(`MLP_OUTPUTS),
		.layerIndex(outputIndex)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.layerIn(hiddenOut),
		.layerOut(layerScores.act)
	);

endmodule

`default_nettype wire

//--- handshakeControl.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlp_settings.svh"

module handshakeControl
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inReq,
	output logic inAck,
	input featureVector features,
	output featureVector captured,
	input scoreVector layerScores,
	output logic outReq,
	input logic outAck,
	output scoreVector scores
);

	localparam int computeCycles = 2 * `MLP_NODE_LATENCY;
	localparam int countBits = $clog2(computeCycles + 1);
	localparam logic [countBits-1:0] countStart = countBits'(computeCycles);

	controlState state;
	logic [countBits-1:0] count;
	logic layersDone;

	assign layersDone = (state == sCompute) && (count == '0);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sIdle;
			inAck <= 1'b0;
			outReq <= 1'b0;
			count <= '0;
			captured <= '0;
		end
		else
		begin
			if (count != '0)
				count <= count - 1'b1; // runs while the input side finishes.

			case (state)
				sIdle:
				begin
					if (inReq)
					begin
						captured <= features; // capture edge.
						inAck <= 1'b1;
						count <= countStart;
						state <= sWaitReqLow;
					end
				end
				sWaitReqLow:
				begin
					if (!inReq)
					begin
						inAck <= 1'b0;
						state <= sCompute;
					end
				end
				sCompute:
				begin
					if (layersDone)
					begin
						outReq <= 1'b1;
						state <= sOffer;
					end
				end
				sOffer:
				begin
					if (outAck)
					begin
						outReq <= 1'b0;
						state <= sWaitAckLow;
					end
				end
				sWaitAckLow:
				begin
					if (!outAck)
						state <= sIdle;
				end
				default:
					state <= sIdle;
			endcase
		end
	end

	// result register, held until the next count ends.
	always_ff @(posedge clk)
	begin
		if (layersDone)
			scores <= layerScores;
	end

endmodule

`default_nettype wire

//--- denseLayer.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlp_settings.svh"

module denseLayer
	import mlpPkg::*;
#(
	parameter int width = `MLP_HIDDEN,
	parameter int layerIndex = hiddenIndex
)
(
	input logic clk,
	input logic reset,
	input featureVector layerIn,
	output activation [0:width-1] layerOut
);

	// every node sees the same input vector.
	generate
		for (genvar n = 0; n < width; n++)
		begin : node
			if (layerIndex == hiddenIndex)
			begin : hidden
				neuronNode #(
					.weights(hiddenWeights[n]),
					.nodeBias(hiddenBiases[n])
				) u_neuron (
					.clk(clk),
					.reset(reset),
					.inputs(layerIn),
					.nodeOut(layerOut[n])
				);
			end
			else
			begin : scoreNode
				neuronNode #(
					.weights(outputWeights[n]),
					.nodeBias(outputBiases[n])
				) u_neuron (
					.clk(clk),
					.reset(reset),
					.inputs(layerIn),
					.nodeOut(layerOut[n])
				);
			end
		end
	endgenerate

endmodule

`default_nettype wire

//--- neuronNode.sv
`timescale 1ns/1ps
`default_nettype none
`include "mlp_settings.svh"

module neuronNode
	import mlpPkg::*;
#(
	parameter weightRow weights = '0,
	parameter bias nodeBias = '0
)
(
	input logic clk,
	input logic reset,
	input featureVector inputs,
	output activation nodeOut
);

	localparam int fieldTop = `MLP_FRAC_SHIFT + `MLP_ACT_WIDTH - 1;
	localparam int accTop = `MLP_ACC_WIDTH - 1;
	localparam logic [`MLP_ACT_WIDTH:0] roundMax = `MLP_ACT_MAX;

	featureVector inputReg;
	accumulator sum;
	accumulator accReg;
	logic [`MLP_ACT_WIDTH:0] rounded;
	activation nextOut;

	// multiply-accumulate over the registered inputs.
	always_comb
	begin
		sum = accumulator'(nodeBias);
		for (int i = 0; i < `MLP_FEATURES; i++)
		begin
			sum = sum + accumulator'(inputReg.act[i] * weights[i]); // exact in 23 bits.
		end
	end

	// rectify, then saturate or round the output field.
	always_comb
	begin
		rounded = {1'b0, accReg[fieldTop:`MLP_FRAC_SHIFT]}
			+ (`MLP_ACT_WIDTH+1)'(accReg[`MLP_FRAC_SHIFT-1]);
		if (accReg[accTop])
			nextOut = '0; // negative.
		else if (|accReg[accTop-1:fieldTop])
			nextOut = activation'(`MLP_ACT_MAX); // too large.
		else if (rounded > roundMax)
			nextOut = activation'(`MLP_ACT_MAX); // 127.5 rounds up past the range.
		else
			nextOut = activation'(rounded[`MLP_ACT_WIDTH-1:0]);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputReg <= '0;
			accReg <= '0;
			nodeOut <= '0;
		end
		else
		begin
			inputReg <= inputs;
			accReg <= sum;
			nodeOut <= nextOut;
		end
	end

endmodule

`default_nettype wire

//--- mlpPkg.sv
`default_nettype none
`include "mlp_settings.svh"

package mlpPkg;

	typedef logic signed [`MLP_ACT_WIDTH-1:0] activation;
	typedef logic signed [`MLP_ACT_WIDTH-1:0] weight;
	typedef logic signed [`MLP_BIAS_WIDTH-1:0] bias;
	typedef logic signed [`MLP_ACC_WIDTH-1:0] accumulator;

	typedef struct packed {
		activation [0:`MLP_FEATURES-1] act; // also carries the hidden layer outputs.
	} featureVector;

	typedef struct packed {
		activation [0:`MLP_OUTPUTS-1] act;
	} scoreVector;

	typedef weight [0:`MLP_FEATURES-1] weightRow; // fan-in of one neuron.

	typedef enum logic [2:0] {
		sIdle,
		sWaitReqLow,
		sCompute,
		sOffer,
		sWaitAckLow
	} controlState;

	localparam int hiddenIndex = 0;
	localparam int outputIndex = 1;

	localparam weightRow hiddenWeights [`MLP_HIDDEN] = '{
		'{8'sd22, -8'sd31, -8'sd17, 8'sd31, 8'sd10,
			8'sd14, -8'sd9, 8'sd7, -8'sd14, -8'sd31},
		'{-8'sd5, 8'sd18, 8'sd27, -8'sd12, 8'sd3,
			-8'sd25, 8'sd9, 8'sd30, -8'sd7, 8'sd16},
		'{8'sd11, 8'sd4, -8'sd20, -8'sd29, 8'sd24,
			8'sd6, -8'sd13, 8'sd19, 8'sd28, -8'sd2},
		'{-8'sd18, 8'sd25, 8'sd8, 8'sd13, -8'sd30,
			8'sd21, 8'sd2, -8'sd11, 8'sd5, 8'sd26},
		'{8'sd29, -8'sd6, 8'sd15, -8'sd23, -8'sd1,
			8'sd12, 8'sd27, -8'sd19, 8'sd20, -8'sd8},
		'{-8'sd27, -8'sd14, 8'sd31, 8'sd6, 8'sd17,
			-8'sd3, -8'sd22, 8'sd10, 8'sd13, 8'sd24},
		'{8'sd3, 8'sd20, -8'sd9, 8'sd18, -8'sd26,
			8'sd30, -8'sd15, -8'sd4, 8'sd23, 8'sd7},
		'{8'sd16, -8'sd28, 8'sd12, -8'sd2, 8'sd21,
			-8'sd17, 8'sd25, 8'sd29, -8'sd10, -8'sd19},
		'{-8'sd12, 8'sd9, -8'sd24, 8'sd27, 8'sd14,
			8'sd8, -8'sd30, 8'sd1, 8'sd18, -8'sd21},
		'{8'sd7, 8'sd23, 8'sd5, -8'sd16, -8'sd11,
			8'sd28, 8'sd19, -8'sd27, -8'sd6, 8'sd15}
	};

	localparam bias hiddenBiases [`MLP_HIDDEN] = '{
		-16'sd512, 16'sd384, 16'sd1024, -16'sd256, 16'sd768,
		16'sd0, 16'sd2048, -16'sd1024, 16'sd640, 16'sd128
	};

	localparam weightRow outputWeights [`MLP_OUTPUTS] = '{
		'{8'sd19, -8'sd8, 8'sd14, 8'sd25, -8'sd21,
			8'sd6, 8'sd11, -8'sd16, 8'sd30, -8'sd4},
		'{-8'sd13, 8'sd27, -8'sd5, 8'sd9, 8'sd17,
			-8'sd24, 8'sd3, 8'sd22, -8'sd18, 8'sd12},
		'{8'sd24, 8'sd2, -8'sd29, -8'sd7, 8'sd13,
			8'sd20, -8'sd12, 8'sd8, 8'sd15, -8'sd26},
		'{-8'sd9, -8'sd17, 8'sd21, 8'sd11, -8'sd3,
			8'sd28, 8'sd16, -8'sd22, -8'sd14, 8'sd31}
	};

	localparam bias outputBiases [`MLP_OUTPUTS] = '{
		16'sd256, -16'sd384, 16'sd512, -16'sd128
	};

endpackage

`default_nettype wire

//--- mlp_settings.svh
`ifndef MLP_SETTINGS_SVH
`define MLP_SETTINGS_SVH

// network shape.
`define MLP_FEATURES 10
`define MLP_HIDDEN 10
`define MLP_OUTPUTS 4

// cycles from a neuron input change to its output.
`define MLP_NODE_LATENCY 3

// accumulator bit where the 8-bit output field starts.
`define MLP_FRAC_SHIFT 6

// word widths.
`define MLP_ACT_WIDTH 8
`define MLP_BIAS_WIDTH 16
`define MLP_ACC_WIDTH 23

// largest positive activation.
`define MLP_ACT_MAX 127

`endif
